// ==== dsi_cfg.svh ====
`ifndef DSI_CFG_SVH
`define DSI_CFG_SVH

// reset values of the LP timing registers, in clk_sys cycles
`define DSI_T_LPX_DEF        8'd100
`define DSI_T_HS_PREPARE_DEF 8'd50
`define DSI_T_HS_EXIT_DEF    8'd100

// word addresses on the 3-bit wishbone address
`define DSI_ADR_CTRL         3'd0
`define DSI_ADR_T_LPX        3'd1
`define DSI_ADR_T_PREP       3'd2
`define DSI_ADR_T_EXIT       3'd3
`define DSI_ADR_STATUS       3'd4

// leader sent at the start of every burst
`define DSI_SYNC_BYTE        8'hB8

// wishbone data width
`define DSI_WB_DW            32

`endif

// ==== dsi_pkg.sv ====
`default_nettype none

`include "dsi_cfg.svh"

package dsi_pkg;

    typedef logic [7:0] byte_t;               // payload byte, timing value
    typedef logic [`DSI_WB_DW-1:0] word_t;    // bus word

    // lane FSM states, also reported in STATUS
    typedef enum logic [2:0] {
        LINES_DISABLED = 3'd0,
        IDLE           = 3'd1,
        HS_RQST        = 3'd2,                // LP-01
        HS_PREP        = 3'd3,                // LP-00
        HS_ACTIVE      = 3'd4,                // LP pair released
        HS_EXIT        = 3'd5                 // LP-00 after trail
    } lane_state_t;

endpackage

`default_nettype wire

// ==== dsi_hs_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsi_cfg.svh"

module dsi_hs_lane (
    input  wire                 clk_sys,
    input  wire                 rst_n,

    input  wire                 start_rqst,
    input  wire                 fin_rqst,
    input  wire dsi_pkg::byte_t inp_data,

    output logic                data_rqst,
    output logic                active,
    output logic                fin_ack,
    output logic                serial_hs
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SYNC,
        PH_DATA,
        PH_TRAIL
    } phase_t;

    phase_t         phase;
    logic [2:0]     bit_cnt;
    logic           last_bit;
    logic           shifting;
    dsi_pkg::byte_t sh;
    logic           trail_bit;

    assign last_bit = (bit_cnt == 3'd7);
    assign shifting = (phase == PH_SYNC) || (phase == PH_DATA);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= PH_IDLE;
            bit_cnt   <= 3'd0;
            data_rqst <= 1'b0;
        end else begin
            data_rqst <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start_rqst) begin
                        phase   <= PH_SYNC;
                        bit_cnt <= 3'd0;
                    end
                end
                PH_SYNC, PH_DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;    // wraps at byte end
                    if (bit_cnt == 3'd6) begin
                        data_rqst <= !fin_rqst;   // high in the last bit
                    end
                    if (last_bit) begin
                        phase <= data_rqst ? PH_DATA : PH_TRAIL;
                    end
                end
                PH_TRAIL: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (last_bit) begin
                        phase <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (phase == PH_IDLE && start_rqst) begin
            sh <= `DSI_SYNC_BYTE;
        end else if (shifting) begin
            if (last_bit && data_rqst) begin
                sh <= inp_data;                   // byte from the source
            end else begin
                sh <= sh >> 1;
            end
            if (last_bit) begin
                trail_bit <= ~sh[0];              // inverse of bit 7
            end
        end
    end

    assign active  = (phase != PH_IDLE);
    assign fin_ack = (phase == PH_TRAIL) && last_bit;

    always_comb begin
        case (phase)
            PH_SYNC, PH_DATA: serial_hs = sh[0];  // lsb first
            PH_TRAIL:         serial_hs = trail_bit;
            default:          serial_hs = 1'b0;
        endcase
    end

    // a request is always followed by the first bit of a new payload byte
    rqst_in_burst: assert property (@(posedge clk_sys) disable iff (!rst_n)
        data_rqst |-> active ##1 (phase == PH_DATA && bit_cnt == 3'd0));

endmodule

`default_nettype wire

// ==== dsi_lane_full.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsi_lane_full (
    input  wire                  clk_sys,
    input  wire                  rst_n,

    input  wire                  lines_enable,
    input  wire                  start_rqst,
    input  wire                  fin_rqst,
    input  wire dsi_pkg::byte_t  t_lpx,
    input  wire dsi_pkg::byte_t  t_hs_prepare,
    input  wire dsi_pkg::byte_t  t_hs_exit,
    input  wire dsi_pkg::byte_t  inp_data,

    output dsi_pkg::lane_state_t state,
    output logic                 data_rqst,
    output logic                 active,
    output logic                 serial_hs,
    output logic                 lp_p,
    output logic                 lp_n,
    output logic                 lp_oe
);

    // states timed by the interval counters, in counter order
    localparam dsi_pkg::lane_state_t IVL_STATE [3] = '{
        dsi_pkg::HS_RQST,
        dsi_pkg::HS_PREP,
        dsi_pkg::HS_EXIT
    };

    dsi_pkg::lane_state_t state_next;
    dsi_pkg::byte_t       ivl_load [3];
    logic [2:0]           ivl_done;
    logic                 hs_start;
    logic                 hs_fin_ack;

    assign ivl_load[0] = t_lpx;
    assign ivl_load[1] = t_hs_prepare;
    assign ivl_load[2] = t_hs_exit;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state <= dsi_pkg::LINES_DISABLED;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            dsi_pkg::LINES_DISABLED:
                state_next = lines_enable ? dsi_pkg::IDLE : dsi_pkg::LINES_DISABLED;
            dsi_pkg::IDLE: begin
                if (!lines_enable) begin
                    state_next = dsi_pkg::LINES_DISABLED;
                end else if (start_rqst) begin
                    state_next = dsi_pkg::HS_RQST;
                end else begin
                    state_next = dsi_pkg::IDLE;
                end
            end
            dsi_pkg::HS_RQST:
                state_next = ivl_done[0] ? dsi_pkg::HS_PREP : dsi_pkg::HS_RQST;
            dsi_pkg::HS_PREP:
                state_next = ivl_done[1] ? dsi_pkg::HS_ACTIVE : dsi_pkg::HS_PREP;
            dsi_pkg::HS_ACTIVE:
                state_next = hs_fin_ack ? dsi_pkg::HS_EXIT : dsi_pkg::HS_ACTIVE;
            dsi_pkg::HS_EXIT:
                state_next = ivl_done[2] ? dsi_pkg::IDLE : dsi_pkg::HS_EXIT;
            default:
                state_next = dsi_pkg::LINES_DISABLED;
        endcase
    end

    // loaded on entry, so each timed state lasts N+1 cycles
    for (genvar i = 0; i < 3; i++) begin : g_ivl
        dsi_pkg::byte_t cnt;

        always_ff @(posedge clk_sys or negedge rst_n) begin
            if (!rst_n) begin
                cnt <= '0;
            end else if (state == IVL_STATE[i]) begin
                cnt <= cnt - 8'd1;
            end else if (state_next == IVL_STATE[i]) begin
                cnt <= ivl_load[i];
            end
        end

        assign ivl_done[i] = (state == IVL_STATE[i]) && (cnt == '0);
    end

    // LP levels follow the next state, held through HS
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            lp_p <= 1'b1;
            lp_n <= 1'b1;
        end else begin
            case (state_next)
                dsi_pkg::LINES_DISABLED, dsi_pkg::IDLE: begin
                    lp_p <= 1'b1;
                    lp_n <= 1'b1;
                end
                dsi_pkg::HS_RQST: lp_p <= 1'b0;   // LP-01
                dsi_pkg::HS_PREP: lp_n <= 1'b0;   // LP-00
                default: ;
            endcase
        end
    end

    assign lp_oe = (state != dsi_pkg::HS_ACTIVE) && (state != dsi_pkg::LINES_DISABLED);

    assign hs_start = (state_next == dsi_pkg::HS_ACTIVE) && (state != dsi_pkg::HS_ACTIVE);

    dsi_hs_lane dsi_hs_lane_i (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .start_rqst (hs_start),
        .fin_rqst   (fin_rqst),
        .inp_data   (inp_data),
        .data_rqst  (data_rqst),
        .active     (active),
        .fin_ack    (hs_fin_ack),
        .serial_hs  (serial_hs)
    );

    // LP pair released only in HS with the serializer running and LP-00 held
    lp_oe_low_hs: assert property (@(posedge clk_sys) disable iff (!rst_n)
        (!lp_oe && state != dsi_pkg::LINES_DISABLED) |->
            (state == dsi_pkg::HS_ACTIVE && active && !lp_p && !lp_n));

endmodule

`default_nettype wire

// ==== dsi_lane_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsi_cfg.svh"

module dsi_lane_regs (
    input  wire                       clk_sys,
    input  wire                       rst_n,

    input  wire                       wb_cyc,
    input  wire                       wb_stb,
    input  wire                       wb_we,
    input  wire logic [2:0]           wb_adr,
    input  wire dsi_pkg::word_t       wb_dat_w,
    output dsi_pkg::word_t            wb_dat_r,
    output logic                      wb_ack,

    input  wire dsi_pkg::lane_state_t state,
    input  wire                       active,

    output logic                      lines_enable,
    output logic                      start_rqst,
    output dsi_pkg::byte_t            t_lpx,
    output dsi_pkg::byte_t            t_hs_prepare,
    output dsi_pkg::byte_t            t_hs_exit
);

    logic           wb_req;
    logic           wr_en;
    dsi_pkg::word_t rd_mux;

    assign wb_req = wb_cyc && wb_stb && !wb_ack;    // one ack per strobe
    assign wr_en  = wb_req && wb_we;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            wb_ack <= wb_req;
            if (wb_req) begin
                wb_dat_r <= rd_mux;                 // status sampled here
            end
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            lines_enable <= 1'b0;
            start_rqst   <= 1'b0;
            t_lpx        <= `DSI_T_LPX_DEF;
            t_hs_prepare <= `DSI_T_HS_PREPARE_DEF;
            t_hs_exit    <= `DSI_T_HS_EXIT_DEF;
        end else begin
            start_rqst <= 1'b0;                     // pulse
            if (wr_en) begin
                case (wb_adr)
                    `DSI_ADR_CTRL: begin
                        lines_enable <= wb_dat_w[0];
                        start_rqst   <= wb_dat_w[1];
                    end
                    `DSI_ADR_T_LPX:  t_lpx        <= wb_dat_w[7:0];
                    `DSI_ADR_T_PREP: t_hs_prepare <= wb_dat_w[7:0];
                    `DSI_ADR_T_EXIT: t_hs_exit    <= wb_dat_w[7:0];
                    default: ;                      // STATUS is read-only
                endcase
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (wb_adr)
            `DSI_ADR_CTRL:   rd_mux[0]   = lines_enable;  // start reads 0
            `DSI_ADR_T_LPX:  rd_mux[7:0] = t_lpx;
            `DSI_ADR_T_PREP: rd_mux[7:0] = t_hs_prepare;
            `DSI_ADR_T_EXIT: rd_mux[7:0] = t_hs_exit;
            `DSI_ADR_STATUS: rd_mux[3:0] = {active, state};
            default: ;
        endcase
    end

    // strobe still held through the ack cycle
    ack_stb_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire

// ==== dsi_lane_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsi_lane_top (
    input  wire                 clk_sys,
    input  wire                 rst_n,

    input  wire                 wb_cyc,
    input  wire                 wb_stb,
    input  wire                 wb_we,
    input  wire logic [2:0]     wb_adr,
    input  wire dsi_pkg::word_t wb_dat_w,
    output dsi_pkg::word_t      wb_dat_r,
    output logic                wb_ack,

    input  wire                 fin_rqst,
    input  wire dsi_pkg::byte_t inp_data,
    output logic                data_rqst,
    output logic                active,
    output logic                serial_hs,
    output logic                lp_p,
    output logic                lp_n,
    output logic                lp_oe
);

    logic                 lines_enable;
    logic                 start_rqst;
    dsi_pkg::byte_t       t_lpx;
    dsi_pkg::byte_t       t_hs_prepare;
    dsi_pkg::byte_t       t_hs_exit;
    dsi_pkg::lane_state_t state;

    dsi_lane_regs dsi_lane_regs_i (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .state        (state),
        .active       (active),
        .lines_enable (lines_enable),
        .start_rqst   (start_rqst),
        .t_lpx        (t_lpx),
        .t_hs_prepare (t_hs_prepare),
        .t_hs_exit    (t_hs_exit)
    );

    dsi_lane_full dsi_lane_full_i (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .lines_enable (lines_enable),
        .start_rqst   (start_rqst),
        .fin_rqst     (fin_rqst),
        .t_lpx        (t_lpx),
        .t_hs_prepare (t_hs_prepare),
        .t_hs_exit    (t_hs_exit),
        .inp_data     (inp_data),
        .state        (state),
        .data_rqst    (data_rqst),
        .active       (active),
        .serial_hs    (serial_hs),
        .lp_p         (lp_p),
        .lp_n         (lp_n),
        .lp_oe        (lp_oe)
    );

endmodule

`default_nettype wire

// ==== tb_dsi_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dsi_cfg.svh"

module tb_dsi_lane;

    localparam int TIMEOUT_CYCLES = 20 * (3 * 256 + 8 * 66 + 64) + 2000;

    logic           clk_sys = 1'b0;
    logic           rst_n;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    logic [2:0]     wb_adr;
    dsi_pkg::word_t wb_dat_w;
    dsi_pkg::word_t wb_dat_r;
    logic           wb_ack;
    logic           fin_rqst;
    dsi_pkg::byte_t inp_data;
    logic           data_rqst;
    logic           active;
    logic           serial_hs;
    logic           lp_p;
    logic           lp_n;
    logic           lp_oe;

    int             cycle_cnt = 0;
    int             test_errs = 0;
    int             n_pass = 0;
    int             n_fail = 0;
    dsi_pkg::byte_t exp_lpx;                       // model of the timing registers
    dsi_pkg::byte_t exp_prep;
    dsi_pkg::byte_t exp_exit;

    dsi_lane_top dsi_lane_top_i (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .fin_rqst  (fin_rqst),
        .inp_data  (inp_data),
        .data_rqst (data_rqst),
        .active    (active),
        .serial_hs (serial_hs),
        .lp_p      (lp_p),
        .lp_n      (lp_n),
        .lp_oe     (lp_oe)
    );

    always #2 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic compare_byte(input dsi_pkg::byte_t got, input dsi_pkg::byte_t exp,
                                input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic compare_word(input dsi_pkg::word_t got, input dsi_pkg::word_t exp,
                                input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic compare_state(input dsi_pkg::lane_state_t got,
                                 input dsi_pkg::lane_state_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %s expected %s", $time, what, got.name(),
                     exp.name());
            test_errs++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            #0.5;
        end
    endtask

    // entered and left 0.5 ns after a rising edge
    task automatic wb_write(input logic [2:0] adr, input dsi_pkg::word_t dat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        do begin
            @(posedge clk_sys);
            #0.5;
        end while (!wb_ack);
        @(posedge clk_sys);                        // strobe held through the ack cycle
        #0.5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output dsi_pkg::word_t dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do begin
            @(posedge clk_sys);
            #0.5;
        end while (!wb_ack);
        dat    = wb_dat_r;
        @(posedge clk_sys);
        #0.5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic check_status(input dsi_pkg::lane_state_t exp, input logic exp_active);
        dsi_pkg::word_t rd;
        wb_read(`DSI_ADR_STATUS, rd);
        compare_state(dsi_pkg::lane_state_t'(rd[2:0]), exp, "STATUS state");
        compare_word(dsi_pkg::word_t'(rd[3]), dsi_pkg::word_t'(exp_active), "STATUS active");
    endtask

    task automatic program_timings();
        dsi_pkg::word_t rd;
        exp_lpx  = dsi_pkg::byte_t'($urandom_range(255, 1));
        exp_prep = dsi_pkg::byte_t'($urandom_range(255, 1));
        exp_exit = dsi_pkg::byte_t'($urandom_range(255, 1));
        wb_write(`DSI_ADR_T_LPX, dsi_pkg::word_t'(exp_lpx));
        wb_write(`DSI_ADR_T_PREP, dsi_pkg::word_t'(exp_prep));
        wb_write(`DSI_ADR_T_EXIT, dsi_pkg::word_t'(exp_exit));
        wb_read(`DSI_ADR_T_LPX, rd);
        compare_word(rd, dsi_pkg::word_t'(exp_lpx), "T_LPX readback");
        wb_read(`DSI_ADR_T_PREP, rd);
        compare_word(rd, dsi_pkg::word_t'(exp_prep), "T_PREP readback");
        wb_read(`DSI_ADR_T_EXIT, rd);
        compare_word(rd, dsi_pkg::word_t'(exp_exit), "T_EXIT readback");
    endtask

    // one burst from IDLE back to IDLE, lane monitored cycle by cycle
    task automatic run_burst(input int len);
        dsi_pkg::byte_t payload[$];
        logic           bits[$];
        dsi_pkg::byte_t got;
        dsi_pkg::byte_t exp;
        int             n_lp01 = 0;
        int             n_prep = 0;
        int             n_exit = 0;
        int             sent = 0;
        bit             seen_active = 1'b0;
        bit             done = 1'b0;
        for (int i = 0; i < len; i++) begin
            payload.push_back(dsi_pkg::byte_t'($urandom_range(255, 0)));
        end
        wb_write(`DSI_ADR_CTRL, 32'h3);            // returns in the first LP-01 cycle
        while (!done) begin
            if (active) begin
                seen_active = 1'b1;
                bits.push_back(serial_hs);
                compare_word(dsi_pkg::word_t'(lp_oe), 32'd0, "lp_oe in HS");
            end else if (lp_oe && !lp_p && lp_n) begin
                n_lp01++;
            end else if (lp_oe && !lp_p && !lp_n) begin
                if (seen_active) n_exit++;
                else n_prep++;
            end else if (lp_oe && lp_p && lp_n) begin
                done = 1'b1;                       // back in LP-11
            end else begin
                $display("lane left LP mode without an active burst at %0t", $time);
                test_errs++;
                done = 1'b1;
            end
            if (data_rqst) begin
                inp_data = (sent < len) ? payload[sent] : 8'h00;
                sent++;
                if (sent == len) fin_rqst = 1'b1;
            end
            if (!done) begin
                @(posedge clk_sys);
                #0.5;
            end
        end
        fin_rqst = 1'b0;
        compare_word(dsi_pkg::word_t'(n_lp01), dsi_pkg::word_t'(exp_lpx) + 32'd1,
                     "LP-01 cycles");
        compare_word(dsi_pkg::word_t'(n_prep), dsi_pkg::word_t'(exp_prep) + 32'd1,
                     "LP-00 prep cycles");
        compare_word(dsi_pkg::word_t'(n_exit), dsi_pkg::word_t'(exp_exit) + 32'd1,
                     "LP-00 exit cycles");
        compare_word(dsi_pkg::word_t'(sent), dsi_pkg::word_t'(len), "bytes requested");
        compare_word(dsi_pkg::word_t'(bits.size()), dsi_pkg::word_t'(8 * (len + 2)),
                     "HS bits");
        if (bits.size() == 8 * (len + 2)) begin
            for (int b = 0; b < len + 2; b++) begin
                for (int k = 0; k < 8; k++) got[k] = bits[8 * b + k];
                if (b == 0) exp = `DSI_SYNC_BYTE;
                else if (b <= len) exp = payload[b - 1];
                else exp = {8{~payload[len - 1][7]}};  // trail
                compare_byte(got, exp, (b == 0) ? "sync byte" : "burst byte");
            end
        end
        check_status(dsi_pkg::IDLE, 1'b0);
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            n_pass++;
            $display("test %s: ok, %0d mismatches", name, test_errs);
        end else begin
            n_fail++;
            $display("test %s: %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        dsi_pkg::word_t rd;
        void'($urandom(57));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 3'd0;
        wb_dat_w = '0;
        fin_rqst = 1'b0;
        inp_data = '0;
        repeat (3) @(posedge clk_sys);
        #0.5;
        rst_n = 1'b1;

        // ack, rqst, active, serial, oe low and LP-11 out of reset
        compare_word(dsi_pkg::word_t'({wb_ack, data_rqst, active, serial_hs, lp_oe, lp_p,
                                       lp_n}), 32'd3, "outputs after reset");
        wb_read(`DSI_ADR_T_LPX, rd);
        compare_word(rd, dsi_pkg::word_t'(`DSI_T_LPX_DEF), "T_LPX reset value");
        wb_read(`DSI_ADR_T_PREP, rd);
        compare_word(rd, dsi_pkg::word_t'(`DSI_T_HS_PREPARE_DEF), "T_PREP reset value");
        wb_read(`DSI_ADR_T_EXIT, rd);
        compare_word(rd, dsi_pkg::word_t'(`DSI_T_HS_EXIT_DEF), "T_EXIT reset value");
        check_status(dsi_pkg::LINES_DISABLED, 1'b0);
        program_timings();
        wb_write(`DSI_ADR_CTRL, 32'h2);
        wb_read(`DSI_ADR_CTRL, rd);
        compare_word(rd, 32'd0, "CTRL readback");
        finish_test("reset_regs");

        wb_write(`DSI_ADR_CTRL, 32'h2);            // start while disabled
        idle_cycles(2);
        check_status(dsi_pkg::LINES_DISABLED, 1'b0);
        compare_word(dsi_pkg::word_t'(lp_oe), 32'd0, "lp_oe when disabled");
        wb_write(`DSI_ADR_CTRL, 32'h1);
        idle_cycles(1);
        check_status(dsi_pkg::IDLE, 1'b0);
        compare_word(dsi_pkg::word_t'({lp_oe, lp_p, lp_n}), 32'd7, "LP-11 in IDLE");
        finish_test("disabled_lane");

        run_burst(12);
        finish_test("single_burst");

        for (int r = 0; r < 20; r++) begin
            program_timings();
            if ($urandom_range(1, 0) == 1) begin
                wb_write(`DSI_ADR_CTRL, 32'h0);
                idle_cycles(1);
                check_status(dsi_pkg::LINES_DISABLED, 1'b0);
                wb_write(`DSI_ADR_CTRL, 32'h1);
                idle_cycles(1);
            end
            run_burst($urandom_range(64, 1));
        end
        finish_test("random_bursts");

        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
dsi_pkg.sv
dsi_hs_lane.sv
dsi_lane_full.sv
dsi_lane_regs.sv
dsi_lane_top.sv
tb_dsi_lane.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_dsi_lane -f all.f \
    -o sim_tb_dsi_lane > build.log 2>&1 &&
./obj_dir/sim_tb_dsi_lane > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "TESTS PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
